// ==== test/gfx_stimulus.txt ====
# columns: op reg a b, hex. W write a. R read b times, expect a. w/r b random words, slots a..
# s read b words, expect slot a. P poll reg until bit a is b. I expect a strobes after b cycles
R 0 0000 1   reset values
R a 0000 1
I 0 0000 14
W 0 0300 0   enable blit and timer
R 0 0300 1
W 1 0001 0   write and read back
W 2 0100 0
w 5 0000 4
W 3 0001 0
W 4 0100 0
r 5 0000 4
W 2 0200 0   background at 0x200
w 5 0004 5
W 1 0003 0   strided writes
W 2 0200 0
w 5 0009 2
W 3 0003 0   strided reads
W 4 0200 0
r 5 0009 2
W 3 0001 0   words in between unchanged
W 4 0201 0
r 5 0005 2
r 5 000a 1
r 5 0008 1
w 7 000b 1   fill value
W 6 0100 0
W 8 0003 0
P a 0000 0   wait for blit idle
W 4 0100 0
s 5 000b 3
r 5 0003 1
R 0 0301 1
I 0 0001 0
W 9 0032 0   timer 50 cycles
P 0 0001 1
I 0 0001 0
W 9 0032 0   expiry while pending
I 0 0000 64
W 0 0303 0   clear both
R 0 0300 1

// ==== filelist.f ====
+incdir+source
source/gfx_reg_pkg.sv
source/gfx_mem_pkg.sv
source/reg_interface.sv
source/vram_arb.sv
source/blit_fill.sv
source/intr_unit.sv
source/gfx_main.sv
test/tb_gfx_main.sv

// ==== Makefile ====
TOP := tb_gfx_main

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== test/tb_gfx_main.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "gfx_defines.svh"

module tb_gfx_main;

logic                    clk = 1'b0;
logic                    reset;
logic                    bus_cs_n;
logic                    bus_rd_nwr;
gfx_reg_pkg::reg_num_e   bus_reg_num;
logic                    bus_bytesel;
logic [`GFX_BYTE_W-1:0]  bus_wdata;
logic [`GFX_BYTE_W-1:0]  bus_rdata;
logic                    bus_intr;

logic [31:0]             lcg_state = 32'h4553;
logic [`GFX_WORD_W-1:0]  slot_word [0:15];  // random words by stimulus slot
int                      intr_seen = 0;     // strobe cycles so far
int                      intr_base = 0;     // count at last interrupt check

gfx_main u_gfx_main (
    .clk(clk),
    .reset_i(reset),
    .bus_cs_n_i(bus_cs_n),
    .bus_rd_nwr_i(bus_rd_nwr),
    .bus_reg_num_i(bus_reg_num),
    .bus_bytesel_i(bus_bytesel),
    .bus_data_i(bus_wdata),
    .bus_data_o(bus_rdata),
    .bus_intr_o(bus_intr)
);

always #20 clk = ~clk;              // 40 ns period

always @(posedge clk) begin
    if (bus_intr) begin
        intr_seen <= intr_seen + 1; // strobe is one cycle wide
    end
end

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

task automatic stop_failed(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first failure");
endtask

task automatic check_value(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
    if (actual !== expected) begin
        stop_failed($sformatf("[ERROR] %s expected %h actual %h", name, expected, actual));
    end
endtask

// one byte access followed by the idle gap the cpu guarantees
task automatic bus_byte(input logic rd, input logic [3:0] num, input logic bsel,
                        input logic [7:0] wdata, output logic [7:0] rdata);
    @(posedge clk);
    bus_cs_n    <= 1'b0;
    bus_rd_nwr  <= rd;
    bus_reg_num <= gfx_reg_pkg::reg_num_e'(num);
    bus_bytesel <= bsel;
    bus_wdata   <= wdata;
    @(posedge clk);                 // dut takes the access here
    bus_cs_n    <= 1'b1;
    @(posedge clk);
    rdata = bus_rdata;              // registered one cycle after the access
    repeat (3) @(posedge clk);
endtask

task automatic write_word(input logic [3:0] num, input logic [15:0] value);
    logic [7:0] dummy;
    bus_byte(1'b0, num, 1'b0, value[15:8], dummy);     // even byte latched
    bus_byte(1'b0, num, 1'b1, value[7:0], dummy);      // odd byte commits
endtask

task automatic read_word(input logic [3:0] num, output logic [15:0] value);
    logic [7:0] hi;
    logic [7:0] lo;
    bus_byte(1'b1, num, 1'b0, 8'h00, hi);
    bus_byte(1'b1, num, 1'b1, 8'h00, lo);
    value = {hi, lo};
endtask

task automatic poll_bit(input string name, input logic [3:0] num, input logic [3:0] bitpos,
                        input logic want);
    logic [15:0] word;
    int          tries;
    tries = 0;
    read_word(num, word);
    while (word[bitpos] !== want) begin
        tries++;
        if (tries > 200) begin
            stop_failed($sformatf("%s timed out, bit %0d of register %0d never became %0b",
                                  name, bitpos, num, want));
        end
        read_word(num, word);
    end
endtask

// watch a window and compare strobes seen since the last check
task automatic check_intr(input string name, input int pulses, input int window);
    int cycles;
    cycles = 0;
    while (cycles < window) begin
        @(posedge clk);
        cycles++;
    end
    check_value(name, pulses[15:0], 16'(intr_seen - intr_base));
    intr_base = intr_seen;
endtask

initial begin
    int          fd;
    int          fields;
    int          line_no;
    string       line;
    string       name;
    logic [7:0]  op;
    logic [15:0] num;
    logic [15:0] arg_a;
    logic [15:0] arg_b;
    logic [15:0] word;
    reset       = 1'b1;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b1;
    bus_reg_num = gfx_reg_pkg::INT_CTRL;
    bus_bytesel = 1'b0;
    bus_wdata   = '0;
    line_no     = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    fd = $fopen("test/gfx_stimulus.txt", "r");
    if (fd == 0) begin
        stop_failed("could not open the stimulus file test/gfx_stimulus.txt");
    end
    while ($fgets(line, fd) > 0) begin
        line_no++;
        fields = $sscanf(line, "%c %h %h %h", op, num, arg_a, arg_b);
        if (fields == 4 && op != "#") begin     // comments and blank lines skipped
            name = $sformatf("line %0d op %c", line_no, op);
            case (op)
                "W": write_word(num[3:0], arg_a);
                "R": begin
                    repeat (arg_b) begin
                        read_word(num[3:0], word);
                        check_value(name, arg_a, word);
                    end
                end
                "w": begin
                    for (int i = 0; i < arg_b; i++) begin
                        lcg_state = lcg_next(lcg_state);
                        slot_word[4'(arg_a + i)] = lcg_state[31:16];   // upper bits mix best
                        write_word(num[3:0], slot_word[4'(arg_a + i)]);
                    end
                end
                "r": begin
                    for (int i = 0; i < arg_b; i++) begin
                        read_word(num[3:0], word);
                        check_value(name, slot_word[4'(arg_a + i)], word);
                    end
                end
                "s": begin
                    repeat (arg_b) begin                // same slot every word
                        read_word(num[3:0], word);
                        check_value(name, slot_word[arg_a[3:0]], word);
                    end
                end
                "P": poll_bit(name, num[3:0], arg_a[3:0], arg_b[0]);
                "I": check_intr(name, int'(arg_a), int'(arg_b));
                default: stop_failed($sformatf("%s is not a known stimulus command", name));
            endcase
        end
    end
    $fclose(fd);
    $display("ALL TESTS PASSED");
    $finish;
end

// overall limit on the run
initial begin
    int cycles;
    cycles = 0;
    while (cycles < 100000) begin
        @(posedge clk);
        cycles++;
    end
    stop_failed("timeout, the stimulus did not finish within 100000 cycles");
end

endmodule

`default_nettype wire

// ==== source/gfx_main.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "gfx_defines.svh"

module gfx_main (
    input  wire logic                     clk,
    input  wire logic                     reset_i,
    input  wire logic                     bus_cs_n_i,
    input  wire logic                     bus_rd_nwr_i,
    input  wire gfx_reg_pkg::reg_num_e    bus_reg_num_i,
    input  wire logic                     bus_bytesel_i,
    input  wire logic [`GFX_BYTE_W-1:0]   bus_data_i,
    output logic      [`GFX_BYTE_W-1:0]   bus_data_o,
    output logic                          bus_intr_o
);

// vram port wiring
logic                     regs_vram_sel, regs_vram_ack;
logic                     blit_vram_sel, blit_vram_ack;
gfx_mem_pkg::vram_req_t   regs_vram_req, blit_vram_req;
logic [`GFX_WORD_W-1:0]   vram_data;    // shared read data

// blitter control
logic                     blit_start, blit_busy, blit_done;
gfx_reg_pkg::blit_cmd_t   blit_cmd;

// timer and interrupts
logic                     timer_load;
logic [`GFX_TIMER_W-1:0]  timer_count;
logic                     intr_mask_wr;
gfx_reg_pkg::intr_t       intr_mask_new, intr_clear;
gfx_reg_pkg::intr_t       intr_mask, intr_status;

reg_interface u_reg_interface (
    .clk(clk),
    .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i),
    .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),
    .bus_data_o(bus_data_o),
    .vram_ack_i(regs_vram_ack),
    .vram_data_i(vram_data),
    .vram_sel_o(regs_vram_sel),
    .vram_req_o(regs_vram_req),
    .blit_busy_i(blit_busy),
    .blit_start_o(blit_start),
    .blit_cmd_o(blit_cmd),
    .intr_status_i(intr_status),
    .intr_mask_i(intr_mask),
    .timer_load_o(timer_load),
    .timer_count_o(timer_count),
    .intr_mask_wr_o(intr_mask_wr),
    .intr_mask_o(intr_mask_new),
    .intr_clear_o(intr_clear)
);

vram_arb u_vram_arb (
    .clk(clk),
    .regs_sel_i(regs_vram_sel),
    .regs_req_i(regs_vram_req),
    .blit_sel_i(blit_vram_sel),
    .blit_req_i(blit_vram_req),
    .regs_ack_o(regs_vram_ack),
    .blit_ack_o(blit_vram_ack),
    .vram_data_o(vram_data)
);

blit_fill u_blit_fill (
    .clk(clk),
    .reset_i(reset_i),
    .start_i(blit_start),
    .cmd_i(blit_cmd),
    .vram_ack_i(blit_vram_ack),
    .busy_o(blit_busy),
    .done_o(blit_done),
    .vram_sel_o(blit_vram_sel),
    .vram_req_o(blit_vram_req)
);

intr_unit u_intr_unit (
    .clk(clk),
    .reset_i(reset_i),
    .blit_done_i(blit_done),
    .timer_load_i(timer_load),
    .timer_count_i(timer_count),
    .mask_wr_i(intr_mask_wr),
    .mask_i(intr_mask_new),
    .clear_i(intr_clear),
    .mask_o(intr_mask),
    .status_o(intr_status),
    .bus_intr_o(bus_intr_o)
);

endmodule

`default_nettype wire

// ==== source/intr_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "gfx_defines.svh"

module intr_unit (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire logic                      blit_done_i,
    input  wire logic                      timer_load_i,
    input  wire logic [`GFX_TIMER_W-1:0]   timer_count_i,
    input  wire logic                      mask_wr_i,
    input  wire gfx_reg_pkg::intr_t        mask_i,
    input  wire gfx_reg_pkg::intr_t        clear_i,     // valid with mask_wr_i
    output gfx_reg_pkg::intr_t             mask_o,
    output gfx_reg_pkg::intr_t             status_o,
    output logic                           bus_intr_o
);

logic [`GFX_TIMER_W-1:0] timer_cnt;
logic                    timer_run;
logic                    timer_pulse;   // expiry, one cycle
gfx_reg_pkg::intr_t      src;

assign src.timer = timer_pulse;
assign src.blit  = blit_done_i;

always_ff @(posedge clk) begin
    if (reset_i) begin
        timer_run   <= 1'b0;
        timer_pulse <= 1'b0;
        mask_o      <= '0;
        status_o    <= '0;
        bus_intr_o  <= 1'b0;
    end else begin
        timer_pulse <= 1'b0;
        if (timer_load_i) begin
            timer_cnt <= timer_count_i; // reload restarts the count
            timer_run <= 1'b1;
        end else if (timer_run) begin
            if (timer_cnt > 1) begin
                timer_cnt <= timer_cnt - 1'b1;
            end else begin
                timer_run   <= 1'b0;    // one-shot
                timer_pulse <= 1'b1;
            end
        end

        if (mask_wr_i) begin
            mask_o <= mask_i;
        end
        // only new, enabled sources raise the strobe
        bus_intr_o <= |(src & mask_o & ~status_o);
        status_o   <= (status_o & ~(mask_wr_i ? clear_i : 2'b00)) | src;
    end
end

endmodule

`default_nettype wire

// ==== source/blit_fill.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "gfx_defines.svh"

module blit_fill (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire logic                      start_i,
    input  wire gfx_reg_pkg::blit_cmd_t    cmd_i,
    input  wire logic                      vram_ack_i,
    output logic                           busy_o,
    output logic                           done_o,     // one cycle after last write
    output logic                           vram_sel_o,
    output gfx_mem_pkg::vram_req_t         vram_req_o
);

logic [`GFX_VRAM_AW-1:0] addr;          // next word to write
logic [`GFX_VRAM_AW-1:0] remain;        // words left including current
logic [`GFX_WORD_W-1:0]  value;

// always a write, request follows the counters
assign vram_req_o.wr   = 1'b1;
assign vram_req_o.addr = addr;
assign vram_req_o.data = value;
assign vram_sel_o      = busy_o;        // select held for the whole run

always_ff @(posedge clk) begin
    if (reset_i) begin
        busy_o <= 1'b0;
        done_o <= 1'b0;
    end else begin
        done_o <= 1'b0;
        if (start_i && !busy_o) begin
            if (cmd_i.count == '0) begin
                done_o <= 1'b1;         // nothing to write
            end else begin
                busy_o <= 1'b1;
            end
        end else if (busy_o && vram_ack_i && remain == 1) begin
            busy_o <= 1'b0;             // last word acked
            done_o <= 1'b1;
        end
    end
end

// command and counters
always_ff @(posedge clk) begin
    if (start_i && !busy_o) begin
        addr   <= cmd_i.addr;
        remain <= cmd_i.count;
        value  <= cmd_i.value;
    end else if (busy_o && vram_ack_i) begin
        addr   <= addr + 1'b1;          // wraps at end of vram
        remain <= remain - 1'b1;
    end
end

endmodule

`default_nettype wire

// ==== source/vram_arb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "gfx_defines.svh"

module vram_arb (
    input  wire logic                      clk,
    input  wire logic                      regs_sel_i,
    input  wire gfx_mem_pkg::vram_req_t    regs_req_i,
    input  wire logic                      blit_sel_i,
    input  wire gfx_mem_pkg::vram_req_t    blit_req_i,
    output logic                           regs_ack_o,
    output logic                           blit_ack_o,
    output logic      [`GFX_WORD_W-1:0]    vram_data_o
);

logic [`GFX_WORD_W-1:0] mem [0:`GFX_VRAM_DEPTH-1];

gfx_mem_pkg::grant_e    grant;          // winner this cycle
gfx_mem_pkg::grant_e    owner;          // access in flight, acked now
gfx_mem_pkg::vram_req_t req;            // winner's request

// registers first, blitter waits
always_comb begin
    grant = gfx_mem_pkg::NONE;
    if (owner == gfx_mem_pkg::NONE) begin       // no grant while acking
        if (regs_sel_i) begin
            grant = gfx_mem_pkg::REGS;
        end else if (blit_sel_i) begin
            grant = gfx_mem_pkg::BLIT;
        end
    end
end

assign req = (grant == gfx_mem_pkg::BLIT) ? blit_req_i : regs_req_i;

assign regs_ack_o = (owner == gfx_mem_pkg::REGS);
assign blit_ack_o = (owner == gfx_mem_pkg::BLIT);

always_ff @(posedge clk) begin
    owner <= grant;
    if (grant != gfx_mem_pkg::NONE) begin
        if (req.wr) begin
            mem[req.addr] <= req.data;
        end
        vram_data_o <= mem[req.addr];   // old word on writes, nobody reads it
    end
end

endmodule

`default_nettype wire

// ==== source/reg_interface.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "gfx_defines.svh"

module reg_interface (
    input  wire logic                         clk,
    input  wire logic                         reset_i,
    // host bus
    input  wire logic                         bus_cs_n_i,       // one access per clock when low
    input  wire logic                         bus_rd_nwr_i,     // 1 = read
    input  wire gfx_reg_pkg::reg_num_e        bus_reg_num_i,
    input  wire logic                         bus_bytesel_i,    // 0 = even/high byte
    input  wire logic [`GFX_BYTE_W-1:0]       bus_data_i,
    output logic      [`GFX_BYTE_W-1:0]       bus_data_o,
    // vram port
    input  wire logic                         vram_ack_i,
    input  wire logic [`GFX_WORD_W-1:0]       vram_data_i,
    output logic                              vram_sel_o,
    output gfx_mem_pkg::vram_req_t            vram_req_o,
    // blitter
    input  wire logic                         blit_busy_i,
    output logic                              blit_start_o,
    output gfx_reg_pkg::blit_cmd_t            blit_cmd_o,
    // interrupt unit
    input  wire gfx_reg_pkg::intr_t           intr_status_i,
    input  wire gfx_reg_pkg::intr_t           intr_mask_i,
    output logic                              timer_load_o,
    output logic      [`GFX_TIMER_W-1:0]      timer_count_o,
    output logic                              intr_mask_wr_o,
    output gfx_reg_pkg::intr_t                intr_mask_o,
    output gfx_reg_pkg::intr_t                intr_clear_o
);

logic [`GFX_BYTE_W-1:0]  even_byte;     // high byte held until odd write
logic [`GFX_WORD_W-1:0]  wr_word;       // full word on odd byte write
logic [`GFX_WORD_W-1:0]  rd_word;       // register selected for read
logic [`GFX_WORD_W-1:0]  wr_incr, wr_addr;
logic [`GFX_WORD_W-1:0]  rd_incr, rd_addr;
logic [`GFX_WORD_W-1:0]  rd_next;       // read address after increment
logic [`GFX_WORD_W-1:0]  rd_data;       // prefetch latch
logic [`GFX_WORD_W-1:0]  blit_addr, blit_value, blit_count;
logic                    bus_wr_odd;    // word commit strobe

assign wr_word    = {even_byte, bus_data_i};
assign rd_next    = rd_addr + rd_incr;
assign bus_wr_odd = !bus_cs_n_i && !bus_rd_nwr_i && bus_bytesel_i;

// fill command straight from the register file
assign blit_cmd_o.addr  = blit_addr[`GFX_VRAM_AW-1:0];
assign blit_cmd_o.count = blit_count[`GFX_VRAM_AW-1:0];
assign blit_cmd_o.value = blit_value;

// read mux
always_comb begin
    case (bus_reg_num_i)
        gfx_reg_pkg::INT_CTRL:   rd_word = {6'b0, intr_mask_i, 6'b0, intr_status_i};
        gfx_reg_pkg::WR_INCR:    rd_word = wr_incr;
        gfx_reg_pkg::WR_ADDR:    rd_word = wr_addr;
        gfx_reg_pkg::RD_INCR:    rd_word = rd_incr;
        gfx_reg_pkg::RD_ADDR:    rd_word = rd_addr;
        gfx_reg_pkg::DATA:       rd_word = rd_data;
        gfx_reg_pkg::BLIT_ADDR:  rd_word = blit_addr;
        gfx_reg_pkg::BLIT_VALUE: rd_word = blit_value;
        gfx_reg_pkg::BLIT_COUNT: rd_word = blit_count;
        gfx_reg_pkg::TIMER:      rd_word = timer_count_o;
        gfx_reg_pkg::STATUS:     rd_word = {14'b0, vram_sel_o, blit_busy_i};   // bit 1 outstanding
        default:                 rd_word = '0;
    endcase
end

// bus side, control state and address registers
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_data_o     <= '0;
        vram_sel_o     <= 1'b0;
        blit_start_o   <= 1'b0;
        timer_load_o   <= 1'b0;
        intr_mask_wr_o <= 1'b0;
        intr_mask_o    <= '0;
        intr_clear_o   <= '0;
        wr_incr        <= '0;
        wr_addr        <= '0;
        rd_incr        <= '0;
        rd_addr        <= '0;
    end else begin
        blit_start_o   <= 1'b0;         // strobes last one cycle
        timer_load_o   <= 1'b0;
        intr_mask_wr_o <= 1'b0;

        if (vram_ack_i) begin
            vram_sel_o <= 1'b0;         // access done, release port
        end

        if (!bus_cs_n_i && bus_rd_nwr_i) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
            // odd data read steps and refills the latch
            if (bus_bytesel_i && bus_reg_num_i == gfx_reg_pkg::DATA) begin
                rd_addr         <= rd_next;
                vram_sel_o      <= 1'b1;
                vram_req_o.wr   <= 1'b0;
                vram_req_o.addr <= rd_next[`GFX_VRAM_AW-1:0];
            end
        end

        if (bus_wr_odd) begin
            case (bus_reg_num_i)
                gfx_reg_pkg::INT_CTRL: begin
                    intr_mask_wr_o <= 1'b1;
                    intr_mask_o    <= wr_word[9:8];     // mask in high byte
                    intr_clear_o   <= wr_word[1:0];     // clear bits in low byte
                end
                gfx_reg_pkg::WR_INCR: wr_incr <= wr_word;
                gfx_reg_pkg::WR_ADDR: wr_addr <= wr_word;
                gfx_reg_pkg::RD_INCR: rd_incr <= wr_word;
                gfx_reg_pkg::RD_ADDR: begin
                    rd_addr         <= wr_word;
                    vram_sel_o      <= 1'b1;            // prefetch
                    vram_req_o.wr   <= 1'b0;
                    vram_req_o.addr <= wr_word[`GFX_VRAM_AW-1:0];
                end
                gfx_reg_pkg::DATA: begin
                    vram_sel_o      <= 1'b1;
                    vram_req_o.wr   <= 1'b1;
                    vram_req_o.addr <= wr_addr[`GFX_VRAM_AW-1:0];
                    vram_req_o.data <= wr_word;
                    wr_addr         <= wr_addr + wr_incr;   // post increment
                end
                gfx_reg_pkg::BLIT_COUNT: blit_start_o <= !blit_busy_i;   // ignored while busy
                gfx_reg_pkg::TIMER:      timer_load_o <= 1'b1;
                default: ;
            endcase
        end
    end
end

// payload registers
always_ff @(posedge clk) begin
    if (!bus_cs_n_i && !bus_rd_nwr_i && !bus_bytesel_i) begin
        even_byte <= bus_data_i;
    end
    if (bus_wr_odd) begin
        case (bus_reg_num_i)
            gfx_reg_pkg::BLIT_ADDR:  blit_addr     <= wr_word;
            gfx_reg_pkg::BLIT_VALUE: blit_value    <= wr_word;
            gfx_reg_pkg::BLIT_COUNT: blit_count    <= wr_word;
            gfx_reg_pkg::TIMER:      timer_count_o <= wr_word;
            default: ;
        endcase
    end
    if (vram_ack_i && !vram_req_o.wr) begin
        rd_data <= vram_data_i;         // read word valid with ack
    end
end

endmodule

`default_nettype wire

// ==== source/gfx_mem_pkg.sv ====
`default_nettype none

`include "gfx_defines.svh"

package gfx_mem_pkg;

    // single vram access as seen by the arbiter
    typedef struct packed {
        logic                    wr;       // 1 = write, 0 = read
        logic [`GFX_VRAM_AW-1:0] addr;
        logic [`GFX_WORD_W-1:0]  data;     // ignored on reads
    } vram_req_t;

    // owner of the access in flight
    typedef enum logic [1:0] {
        NONE = 2'd0,            // idle or acking
        REGS = 2'd1,            // cpu register port
        BLIT = 2'd2             // fill engine
    } grant_e;

endpackage

`default_nettype wire

// ==== source/gfx_reg_pkg.sv ====
`default_nettype none

`include "gfx_defines.svh"

package gfx_reg_pkg;

    // cpu visible register slots, 11..15 unused
    typedef enum logic [`GFX_REG_NUM_W-1:0] {
        INT_CTRL   = 4'd0,      // mask high byte, pending low byte
        WR_INCR    = 4'd1,
        WR_ADDR    = 4'd2,
        RD_INCR    = 4'd3,
        RD_ADDR    = 4'd4,      // write starts a prefetch
        DATA       = 4'd5,      // vram data port
        BLIT_ADDR  = 4'd6,
        BLIT_VALUE = 4'd7,
        BLIT_COUNT = 4'd8,      // odd byte write launches the fill
        TIMER      = 4'd9,
        STATUS     = 4'd10      // busy flags, read only
    } reg_num_e;

    // interrupt sources, same layout for mask, pending and clear
    typedef struct packed {
        logic timer;            // bit 1, timer expired
        logic blit;             // bit 0, fill finished
    } intr_t;

    // fill request handed to the blitter
    typedef struct packed {
        logic [`GFX_VRAM_AW-1:0] addr;     // first word
        logic [`GFX_VRAM_AW-1:0] count;    // words to write, 0 is a no-op
        logic [`GFX_WORD_W-1:0]  value;
    } blit_cmd_t;

endpackage

`default_nettype wire

// ==== source/gfx_defines.svh ====
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

// cpu side widths
`define GFX_WORD_W      16      // register and vram word
`define GFX_BYTE_W      8       // host bus is byte wide
`define GFX_REG_NUM_W   4       // 16 register slots

// video ram geometry
`define GFX_VRAM_AW     12      // word address bits
`define GFX_VRAM_DEPTH  4096    // words, must match 2**GFX_VRAM_AW

// one-shot interval timer
`define GFX_TIMER_W     16

`endif
